/* common/audioRom_params.svh */
/*
 * Sizing macros for the audio ROM reader:
 * page size, page and column widths, status busy bit
 */
`default_nettype none

`ifndef AUDIOROM_PARAMS_SVH
`define AUDIOROM_PARAMS_SVH

// data bytes read per flash page
`define AR_PAGE_BYTES 2048

// page (row) address width
`define AR_PAGE_WIDTH 16

// column byte counter, counts up to AR_PAGE_BYTES
`define AR_COL_WIDTH 12

// OIP bit in status register 0xC0
`define AR_BUSY_BIT 0

`endif

`default_nettype wire

/* common/audioRomPkg.sv */
/*
 * Shared types for the audio ROM reader:
 * sequencer states, SPI NAND opcodes,
 * byte exchange request and sample output structs
 */
`default_nettype none

package audioRomPkg;

	// sequencer states
	typedef enum logic [2:0] {
		stIdle,
		stPageCmd,		// page read 0x13 into the cache
		stPollCmd,		// get feature 0xC0
		stPollCheck,
		stReadCmd,		// read from cache header
		stReadData,		// page data bytes
		stGap			// CS high recovery
	} seqState_t;

	// SPI NAND opcodes used by the reader
	typedef enum logic [7:0] {
		opPageRead   = 8'h13,
		opGetFeature = 8'h0F,
		opReadData   = 8'h03
	} flashOp_t;

	// one byte exchange request to the SPI engine
	typedef struct packed {
		logic       start;		// one cycle strobe
		logic [7:0] txByte;
	} spiReq_t;

	// audio sample output
	typedef struct packed {
		logic        valid;		// one cycle strobe
		logic [15:0] data;
	} sample_t;

endpackage

`default_nettype wire

/* design/spiByteEngine.sv */
/*
 * SPI mode 0 byte engine, SCLK at half of iCLK.
 * One byte out and one byte in per start strobe, MSB first.
 */
`timescale 1ns/1ns
`default_nettype none

module spiByteEngine
	import audioRomPkg::*;
(
	input  wire     iCLK,
	input  wire     iRST,
	input  wire spiReq_t iReq,
	input  wire     iMiso,
	output logic    oSclk,
	output logic    oMosi,
	output logic    oDone,
	output logic [7:0] oRd
);

	logic       busyR;
	logic       sclkR;
	logic       doneR;
	logic [2:0] bitCntR;		// rising edges seen minus one
	logic [7:0] shR;			// transmit shifter
	logic [7:0] rxR;
	logic [7:0] rdR;
	logic       rise;
	logic       fall;
	logic       lastRise;

	// first rise comes with the start strobe itself
	assign rise     = busyR ? ~sclkR : iReq.start;
	assign fall     = busyR & sclkR;
	assign lastRise = busyR & ~sclkR & (bitCntR == 3'd6);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			busyR   <= 1'b0;
			sclkR   <= 1'b0;
			doneR   <= 1'b0;
			bitCntR <= 3'd0;
		end
		else
		begin
			doneR <= lastRise;		// byte complete on eighth rise
			if (rise)
			begin
				sclkR   <= 1'b1;
				busyR   <= 1'b1;
				bitCntR <= busyR ? bitCntR + 3'd1 : 3'd0;
			end
			else if (fall)
			begin
				sclkR <= 1'b0;
				if (bitCntR == 3'd7)
					busyR <= 1'b0;
			end
		end
	end

	//------------------------------------------------------------
	// data shifters
	//------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (rise)
			rxR <= {rxR[6:0], iMiso};		// sample on rising SCLK
		if (lastRise)
			rdR <= {rxR[6:0], iMiso};
		if (!busyR && iReq.start)
			shR <= iReq.txByte;
		else if (fall)
			shR <= {shR[6:0], 1'b0};		// next bit on falling SCLK
	end

	// while idle MOSI already shows the pending request's msb
	assign oMosi = busyR ? shR[7] : iReq.txByte[7];
	assign oSclk = sclkR;
	assign oDone = doneR;
	assign oRd   = rdR;

endmodule

`default_nettype wire

/* design/pageCursor.sv */
/*
 * Page cursor.
 * Current page, column byte count, last byte and last page flags.
 */
`timescale 1ns/1ns
`include "audioRom_params.svh"
`default_nettype none

module pageCursor (
	input  wire                       iCLK,
	input  wire                       iRST,
	input  wire                       iLoad,
	input  wire                       iNextPage,
	input  wire                       iByteStep,
	input  wire  [`AR_PAGE_WIDTH-1:0] iStartPage,
	input  wire  [`AR_PAGE_WIDTH-1:0] iEndPage,
	output logic [`AR_PAGE_WIDTH-1:0] oPage,
	output logic                      oLastByte,
	output logic                      oLastPage
);

	logic [`AR_PAGE_WIDTH-1:0] pageR;
	logic [`AR_COL_WIDTH-1:0]  colR;		// data bytes already read in page

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			pageR <= '0;
			colR  <= '0;
		end
		else if (iLoad)
		begin
			pageR <= iStartPage;
			colR  <= '0;
		end
		else if (iNextPage)
		begin
			pageR <= pageR + 1'b1;
			colR  <= '0;
		end
		else if (iByteStep)
			colR <= colR + 1'b1;
	end

	assign oPage     = pageR;
	assign oLastByte = (colR == `AR_COL_WIDTH'(`AR_PAGE_BYTES - 1));
	assign oLastPage = (pageR == iEndPage);

endmodule

`default_nettype wire

/* design/sampleAssembler.sv */
/*
 * Sample assembler.
 * Little-endian byte pairs to 16-bit samples with a valid strobe.
 */
`timescale 1ns/1ns
`default_nettype none

module sampleAssembler
	import audioRomPkg::*;
(
	input  wire        iCLK,
	input  wire        iRST,
	input  wire        iDataPhase,
	input  wire        iByteDone,
	input  wire  [7:0] iByte,
	output sample_t    oSample
);

	logic        hiNextR;		// next data byte is the high byte
	logic        validR;
	logic [7:0]  lowR;
	logic [15:0] dataR;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			hiNextR <= 1'b0;
			validR  <= 1'b0;
		end
		else
		begin
			validR <= iDataPhase & iByteDone & hiNextR;
			if (!iDataPhase)
				hiNextR <= 1'b0;	// every page starts on a low byte
			else if (iByteDone)
				hiNextR <= ~hiNextR;
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (iByteDone && !hiNextR)
			lowR <= iByte;
		if (iByteDone && hiNextR)
			dataR <= {iByte, lowR};
	end

	assign oSample.valid = validR;
	assign oSample.data  = dataR;

endmodule

`default_nettype wire

/* audioRomReader/audioRomReadSequence.sv */
/*
 * SPI NAND read sequencer FSM.
 * Page read, busy poll, read data, page stepping and cycle wrap.
 */
`timescale 1ns/1ns
`include "audioRom_params.svh"
`default_nettype none

module audioRomReadSequence
	import audioRomPkg::*;
(
	input  wire                      iCLK,
	input  wire                      iRST,
	input  wire                      iEnable,
	input  wire                      iCycle,
	input  wire                      iSpiDone,
	input  wire [7:0]                iSpiRd,
	input  wire [`AR_PAGE_WIDTH-1:0] iPage,
	input  wire                      iLastByte,
	input  wire                      iLastPage,
	output spiReq_t                  oSpiReq,
	output logic                     oCsN,
	output logic                     oLoad,
	output logic                     oNextPage,
	output logic                     oByteStep,
	output logic                     oDataPhase,
	output logic                     oDone,
	output logic                     oBusy
);

	localparam logic [7:0] lpStatusAdr = 8'hC0;

	seqState_t   stR;
	seqState_t   gapNextR;		// command that follows the gap
	logic [2:0]  idxR;			// byte index within a command
	logic [2:0]  lastIdx;
	logic [1:0]  gapCntR;
	logic [7:0]  statusR;
	logic [15:0] pageAdr;
	spiReq_t     reqR;
	logic        csNR;
	logic        loadR;
	logic        nextPageR;
	logic        byteStepR;
	logic        doneReqR;
	logic        doneR;
	logic        waitLowR;		// holds idle after done until enable drops

	assign pageAdr = 16'(iPage);

	// byte sent at position idx of a command
	function automatic logic [7:0] cmdByte(input seqState_t st, input logic [2:0] idx,
		input logic [15:0] pg);
		logic [7:0] b;
		b = 8'h00;					// dummy, column and read slots
		case (st)
		stPageCmd:
		begin
			case (idx)
			3'd0:    b = opPageRead;
			3'd2:    b = pg[15:8];	// row address msb
			3'd3:    b = pg[7:0];
			default: b = 8'h00;
			endcase
		end
		stPollCmd:
		begin
			if (idx == 3'd0)
				b = opGetFeature;
			else if (idx == 3'd1)
				b = lpStatusAdr;
		end
		stReadCmd:
		begin
			if (idx == 3'd0)
				b = opReadData;
		end
		default: b = 8'h00;
		endcase
		return b;
	endfunction

	always_comb
	begin
		case (stR)
		stPollCmd: lastIdx = 3'd2;	// opcode, address, status
		default:   lastIdx = 3'd3;
		endcase
	end

	//------------------------------------------------------------
	// command sequencing
	//------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			stR       <= stIdle;
			gapNextR  <= stPageCmd;
			idxR      <= 3'd0;
			gapCntR   <= 2'd0;
			reqR      <= '0;
			csNR      <= 1'b1;
			loadR     <= 1'b0;
			nextPageR <= 1'b0;
			byteStepR <= 1'b0;
			doneReqR  <= 1'b0;
			doneR     <= 1'b0;
			waitLowR  <= 1'b0;
		end
		else
		begin
			reqR.start <= 1'b0;
			loadR      <= 1'b0;
			nextPageR  <= 1'b0;
			byteStepR  <= 1'b0;
			doneReqR   <= 1'b0;
			doneR      <= doneReqR;		// lands one cycle after last sample
			case (stR)
			stIdle:
			begin
				csNR <= 1'b1;
				if (iEnable && !waitLowR)
				begin
					loadR    <= 1'b1;
					gapNextR <= stPageCmd;
					gapCntR  <= 2'd0;
					stR      <= stGap;
				end
			end
			stGap:
			begin
				gapCntR <= gapCntR + 2'd1;
				if (gapCntR == 2'd3)
				begin
					csNR        <= 1'b0;
					idxR        <= 3'd0;
					reqR.start  <= 1'b1;
					reqR.txByte <= cmdByte(gapNextR, 3'd0, pageAdr);
					stR         <= gapNextR;
				end
			end
			stPageCmd, stPollCmd, stReadCmd:
			begin
				if (iSpiDone && idxR != lastIdx)
				begin
					idxR        <= idxR + 3'd1;
					reqR.start  <= 1'b1;
					reqR.txByte <= cmdByte(stR, idxR + 3'd1, pageAdr);
				end
				else if (iSpiDone)
				begin
					gapCntR <= 2'd0;
					if (stR == stPageCmd)
					begin
						csNR     <= 1'b1;
						gapNextR <= stPollCmd;
						stR      <= stGap;
					end
					else if (stR == stPollCmd)
					begin
						csNR <= 1'b1;
						stR  <= stPollCheck;
					end
					else
					begin
						reqR.start  <= 1'b1;	// first data byte, CS stays low
						reqR.txByte <= 8'h00;
						stR         <= stReadData;
					end
				end
			end
			stPollCheck:
			begin
				gapNextR <= statusR[`AR_BUSY_BIT] ? stPollCmd : stReadCmd;
				gapCntR  <= 2'd0;
				stR      <= stGap;
			end
			stReadData:
			begin
				if (iSpiDone && !iLastByte)
				begin
					byteStepR   <= 1'b1;
					reqR.start  <= 1'b1;
					reqR.txByte <= 8'h00;
				end
				else if (iSpiDone)
				begin
					csNR    <= 1'b1;
					gapCntR <= 2'd0;
					if (iLastPage && !iCycle)
					begin
						doneReqR <= 1'b1;
						waitLowR <= 1'b1;
						stR      <= stIdle;
					end
					else if (!iEnable)
						stR <= stIdle;			// stop at page boundary
					else
					begin
						loadR     <= iLastPage;	// wrap in cycle mode
						nextPageR <= !iLastPage;
						gapNextR  <= stPageCmd;
						stR       <= stGap;
					end
				end
			end
			default: stR <= stIdle;
			endcase
			if (!iEnable)
				waitLowR <= 1'b0;
		end
	end

	// status byte of the poll
	always_ff @(posedge iCLK)
	begin
		if (stR == stPollCmd && iSpiDone && idxR == lastIdx)
			statusR <= iSpiRd;
	end

	assign oSpiReq    = reqR;
	assign oCsN       = csNR;
	assign oLoad      = loadR;
	assign oNextPage  = nextPageR;
	assign oByteStep  = byteStepR;
	assign oDataPhase = (stR == stReadData);
	assign oDone      = doneR;
	assign oBusy      = (stR != stIdle);

endmodule

`default_nettype wire

/* audioRomReader/audioRomReader.sv */
/*
 * Audio ROM reader top level.
 * Command sequencer, SPI byte engine, page cursor and sample assembler.
 */
`timescale 1ns/1ns
`include "audioRom_params.svh"
`default_nettype none

module audioRomReader
	import audioRomPkg::*;
(
	input  wire                      iCLK,
	input  wire                      iRST,
	input  wire                      iEnable,
	input  wire                      iCycle,
	input  wire [`AR_PAGE_WIDTH-1:0] iStartPage,
	input  wire [`AR_PAGE_WIDTH-1:0] iEndPage,
	input  wire                      iMiso,
	output logic                     oSclk,
	output logic                     oMosi,
	output logic                     oCsN,
	output sample_t                  oSample,
	output logic                     oDone,
	output logic                     oBusy
);

	spiReq_t                   spiReq;
	logic                      spiDone;
	logic [7:0]                spiRd;
	logic [`AR_PAGE_WIDTH-1:0] page;
	logic                      lastByte;
	logic                      lastPage;
	logic                      load;
	logic                      nextPage;
	logic                      byteStep;
	logic                      dataPhase;

	audioRomReadSequence audioRomReadSequence_inst (
		.iCLK       (iCLK),
		.iRST       (iRST),
		.iEnable    (iEnable),
		.iCycle     (iCycle),
		.iSpiDone   (spiDone),
		.iSpiRd     (spiRd),
		.iPage      (page),
		.iLastByte  (lastByte),
		.iLastPage  (lastPage),
		.oSpiReq    (spiReq),
		.oCsN       (oCsN),
		.oLoad      (load),
		.oNextPage  (nextPage),
		.oByteStep  (byteStep),
		.oDataPhase (dataPhase),
		.oDone      (oDone),
		.oBusy      (oBusy)
	);

	spiByteEngine spiByteEngine_inst (
		.iCLK  (iCLK),
		.iRST  (iRST),
		.iReq  (spiReq),
		.iMiso (iMiso),
		.oSclk (oSclk),
		.oMosi (oMosi),
		.oDone (spiDone),
		.oRd   (spiRd)
	);

	pageCursor pageCursor_inst (
		.iCLK       (iCLK),
		.iRST       (iRST),
		.iLoad      (load),
		.iNextPage  (nextPage),
		.iByteStep  (byteStep),
		.iStartPage (iStartPage),
		.iEndPage   (iEndPage),
		.oPage      (page),
		.oLastByte  (lastByte),
		.oLastPage  (lastPage)
	);

	sampleAssembler sampleAssembler_inst (
		.iCLK       (iCLK),
		.iRST       (iRST),
		.iDataPhase (dataPhase),
		.iByteDone  (spiDone),
		.iByte      (spiRd),
		.oSample    (oSample)
	);

endmodule

`default_nettype wire

/* tests/spiNandModel.sv */
/*
 * Behavioral SPI NAND for the reader testbench.
 * Page read, get feature and read data with patterned page bytes,
 * busy time set per page read, protocol error reports.
 */
`timescale 1ns/1ns
`include "audioRom_params.svh"
`default_nettype none

module spiNandModel
	import audioRomPkg::*;
(
	input  wire       csN,
	input  wire       sclk,
	input  wire       mosi,
	input  wire [2:0] busyLen,		// polls that still report busy
	output logic      miso,
	output logic      protoErr
);

	logic        misoR     = 1'b0;
	logic        errR      = 1'b0;
	logic        csPrev    = 1'b1;
	logic        sclkPrev  = 1'b0;
	logic [7:0]  rxSh      = 8'h00;
	logic [7:0]  txSh      = 8'h00;
	logic [7:0]  nextTx    = 8'h00;	// byte shifted out after the current one
	logic [7:0]  opcode    = 8'h00;
	logic [15:0] rowAdr    = 16'h0000;
	int          bitCnt    = 0;
	int          byteIdx   = 0;
	int          busyLeft  = 0;
	int          cachePage = 0;

	// page data rule
	function automatic logic [7:0] patternByte(input int page, input int col);
		return 8'((page * 3 + col) % 256);
	endfunction

	task automatic reportError(input string why);
		$display("flash model: %s", why);
		errR = 1'b1;
	endtask

	// decode a complete byte and pick the next reply byte
	task automatic takeByte(input logic [7:0] b);
		nextTx = 8'h00;
		if (byteIdx == 0)
		begin
			opcode = b;
			if (b != opPageRead && b != opGetFeature && b != opReadData)
				reportError($sformatf("unknown command byte %h", b));
			else if (b == opReadData && busyLeft != 0)
				reportError("read data command arrived while the flash was still busy");
		end
		else if (opcode == opGetFeature && byteIdx == 1)
		begin
			if (b != 8'hC0)
				reportError("get feature addressed a register other than 0xC0");
			nextTx[`AR_BUSY_BIT] = (busyLeft != 0);
			if (busyLeft != 0)
				busyLeft = busyLeft - 1;
		end
		else if (opcode == opPageRead && byteIdx == 2)
			rowAdr[15:8] = b;
		else if (opcode == opPageRead && byteIdx == 3)
			rowAdr[7:0] = b;
		if (opcode == opReadData && byteIdx >= 3)
			nextTx = patternByte(cachePage, byteIdx - 3);	// column zero follows the dummy
	endtask

	//------------------------------------------------------------
	// SPI mode 0 slave
	//------------------------------------------------------------
	always @(csN or sclk)
	begin
		if (csN === 1'b0 && csPrev !== 1'b0)
		begin
			bitCnt  = 0;		// new command
			byteIdx = 0;
			opcode  = 8'h00;
			nextTx  = 8'h00;
			misoR   = 1'b0;
		end
		else if (csN === 1'b1 && csPrev !== 1'b1)
		begin
			if (bitCnt != 0)
				reportError("chip select rose in the middle of a byte");
			if (opcode == opPageRead && byteIdx == 4)
			begin
				cachePage = int'(rowAdr);
				busyLeft  = int'(busyLen);	// array load starts
			end
		end
		if (sclk === 1'b1 && sclkPrev !== 1'b1)
		begin
			if (csN !== 1'b0)
				reportError("SCLK rose while chip select was high");
			else
			begin
				rxSh   = {rxSh[6:0], mosi};
				bitCnt = bitCnt + 1;
				if (bitCnt == 8)
				begin
					bitCnt = 0;
					takeByte(rxSh);
					byteIdx = byteIdx + 1;
				end
			end
		end
		else if (sclk === 1'b0 && sclkPrev !== 1'b0 && csN === 1'b0)
		begin
			txSh  = (bitCnt == 0) ? nextTx : {txSh[6:0], 1'b0};
			misoR = txSh[7];
		end
		csPrev   = csN;
		sclkPrev = sclk;
	end

	assign miso     = misoR;
	assign protoErr = errR;

endmodule

`default_nettype wire

/* tests/audioRomReaderTb.sv */
/*
 * Testbench for the audio ROM reader.
 * Stimulus table, LCG busy lengths, sample scoreboard, watchdog.
 */
`timescale 1ns/1ns
`include "audioRom_params.svh"
`default_nettype none

module audioRomReaderTb
	import audioRomPkg::*;
;

	localparam int lpRows        = 4;
	localparam int lpPageSamples = `AR_PAGE_BYTES / 2;

	typedef struct {
		string name;
		int    startPage;
		int    endPage;
		bit    cycle;
		int    samples;		// samples checked before the stop
	} testRow_t;

	logic                      iCLK     = 1'b0;
	logic                      iRST     = 1'b1;
	logic                      iEnable;
	logic                      iCycle;
	logic [`AR_PAGE_WIDTH-1:0] iStartPage;
	logic [`AR_PAGE_WIDTH-1:0] iEndPage;
	wire                       iMiso;
	wire                       oSclk;
	wire                       oMosi;
	wire                       oCsN;
	sample_t                   oSample;
	wire                       oDone;
	wire                       oBusy;
	wire                       protoErr;
	logic [31:0]               lcgState = 32'hf156;
	testRow_t                  rows[lpRows];

	audioRomReader audioRomReader_inst (
		.iCLK       (iCLK),
		.iRST       (iRST),
		.iEnable    (iEnable),
		.iCycle     (iCycle),
		.iStartPage (iStartPage),
		.iEndPage   (iEndPage),
		.iMiso      (iMiso),
		.oSclk      (oSclk),
		.oMosi      (oMosi),
		.oCsN       (oCsN),
		.oSample    (oSample),
		.oDone      (oDone),
		.oBusy      (oBusy)
	);

	spiNandModel spiNandModel_inst (
		.csN      (oCsN),
		.sclk     (oSclk),
		.mosi     (oMosi),
		.busyLen  (lcgState[18:16]),
		.miso     (iMiso),
		.protoErr (protoErr)
	);

	always #10 iCLK = ~iCLK;

	function automatic logic [31:0] nextRand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] patternByte(input int page, input int col);
		return 8'((page * 3 + col) % 256);
	endfunction

	always @(negedge iCLK)
		lcgState <= nextRand(lcgState);	// new busy length every cycle

	task automatic stopOnError();
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("ERROR %s: expected %h, actual %h", what, expected, actual);
			stopOnError();
		end
	endtask

	task automatic setRow(input int idx, input string name, input int startPage,
		input int endPage, input bit cycle, input int samples);
		rows[idx].name      = name;
		rows[idx].startPage = startPage;
		rows[idx].endPage   = endPage;
		rows[idx].cycle     = cycle;
		rows[idx].samples   = samples;
	endtask

	task automatic checkIdle(input string what);
		checkValue({what, " csN"}, 1, oCsN);
		checkValue({what, " sclk"}, 0, oSclk);
		checkValue({what, " sample valid"}, 0, oSample.valid);
		checkValue({what, " done"}, 0, oDone);
		checkValue({what, " busy"}, 0, oBusy);
	endtask

	//------------------------------------------------------------
	// one table row with its scoreboard
	//------------------------------------------------------------
	task automatic runRow(input testRow_t row);
		int          page;
		int          k;
		int          count;
		bit          finished;
		logic [15:0] expected;
		page       = row.startPage;
		k          = 0;
		count      = 0;
		finished   = 1'b0;
		iStartPage = row.startPage[`AR_PAGE_WIDTH-1:0];
		iEndPage   = row.endPage[`AR_PAGE_WIDTH-1:0];
		iCycle     = row.cycle;
		iEnable    = 1'b1;
		while (!finished)
		begin
			@(negedge iCLK);
			if (oSample.valid)
			begin
				expected = {patternByte(page, 2 * k + 1), patternByte(page, 2 * k)};
				checkValue($sformatf("%s page %0d sample %0d", row.name, page, k),
					{16'd0, expected}, {16'd0, oSample.data});
				count++;
				k++;
				if (k == lpPageSamples)
				begin
					k    = 0;
					page = (page == row.endPage) ? row.startPage : page + 1;
				end
				if (k != 0)
					checkValue({row.name, " busy while reading"}, 1, oBusy);	// mid page
				if (row.cycle && count == row.samples)
					iEnable = 1'b0;		// request a stop
			end
			if (row.cycle)
				checkValue({row.name, " done pulse in cycle mode"}, 0, oDone);
			else if (oDone)
			begin
				checkValue({row.name, " sample count"}, row.samples, count);
				finished = 1'b1;
			end
			if (row.cycle && !iEnable && !oBusy)
				finished = 1'b1;
		end
		if (row.cycle)
			checkValue({row.name, " stop at page boundary"}, 0, count % lpPageSamples);
		repeat (64)
		begin
			@(negedge iCLK);
			checkValue({row.name, " sample after end"}, 0, oSample.valid);
			checkValue({row.name, " done after end"}, 0, oDone);
			checkValue({row.name, " busy after end"}, 0, oBusy);
		end
		iEnable = 1'b0;
		repeat (4) @(negedge iCLK);
	endtask

	always @(posedge protoErr)
		stopOnError();

	// watchdog sized from the table
	initial
	begin
		int limit;
		limit = 1000;
		@(negedge iRST);
		for (int i = 0; i < lpRows; i++)
			limit += rows[i].samples * 40 + (rows[i].samples / lpPageSamples + 2) * 3000;
		repeat (limit) @(posedge iCLK);
		$display("timeout: no end of the tests after %0d clock cycles", limit);
		stopOnError();
	end

	initial
	begin
		iEnable    = 1'b0;
		iCycle     = 1'b0;
		iStartPage = '0;
		iEndPage   = '0;
		setRow(0, "singlePage", 5, 5, 1'b0, 1024);
		setRow(1, "threePages", 10, 12, 1'b0, 3072);
		setRow(2, "busyPolling", 16'h00FF, 16'h0101, 1'b0, 3072);	// row msb changes
		setRow(3, "cycleMode", 7, 8, 1'b1, 2560);	// stop requested mid page
		repeat (5)
		begin
			@(negedge iCLK);
			checkIdle("during reset");
		end
		iRST = 1'b0;
		repeat (8)
		begin
			@(negedge iCLK);
			checkIdle("after reset");
		end
		for (int i = 0; i < lpRows; i++)
			runRow(rows[i]);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+common
common/audioRomPkg.sv
design/spiByteEngine.sv
design/pageCursor.sv
design/sampleAssembler.sv
audioRomReader/audioRomReadSequence.sv
audioRomReader/audioRomReader.sv
tests/spiNandModel.sv
tests/audioRomReaderTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the audio ROM reader testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module audioRomReaderTb \
	-f filelist.f -o audioRomReaderSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "verilator build failed with status $buildStatus"
	exit 1
fi

simOut=$(./obj_dir/audioRomReaderSim 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "PASS: all tests" <<< "$simOut"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1
